// ==== icache.sv ====
`default_nettype none

module icache import rv32i_types::*; (
	input wire clk,
	input wire rst_n,
	input wire req_valid,
	output logic req_ready,
	input wire [31:0] req_addr,
	output logic resp_valid,
	input wire resp_ready,
	output logic [31:0] resp_data,
	output logic pmem_read,
	output logic [31:0] pmem_addr,
	input wire pmem_resp,
	input wire icache_line_t pmem_rdata
);

icache_addr_t addr;
logic busy;
logic hit;
logic load_lru;
logic [num_ways-1:0] way_hit;
logic [num_ways-1:0] victim;
logic [num_ways-1:0] load_line;
logic [num_ways-1:0] set_valid;
icache_line_t way_line [num_ways];

assign pmem_addr = {addr.f.tag, addr.f.index, {offset_bits{1'b0}}}; // Line aligned.

icache_request request_i (
	.clk(clk),
	.rst_n(rst_n),
	.req_valid(req_valid),
	.req_addr(req_addr),
	.accept(req_ready),
	.addr(addr),
	.busy(busy)
);

for (genvar w = 0; w < num_ways; w++) begin : g_way
	icache_way way_i (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.load_line(load_line[w]),
		.set_valid(set_valid[w]),
		.fill_line(pmem_rdata),
		.hit(way_hit[w]),
		.line(way_line[w])
	);
end

icache_way_select way_select_i (
	.clk(clk),
	.rst_n(rst_n),
	.addr(addr),
	.way_hit(way_hit),
	.way_line(way_line),
	.load_lru(load_lru),
	.hit(hit),
	.word(resp_data),
	.victim(victim)
);

icache_control control_i (
	.clk(clk),
	.rst_n(rst_n),
	.busy(busy),
	.hit(hit),
	.victim(victim),
	.resp_ready(resp_ready),
	.pmem_resp(pmem_resp),
	.accept(req_ready),
	.resp_valid(resp_valid),
	.pmem_read(pmem_read),
	.load_line(load_line),
	.set_valid(set_valid),
	.load_lru(load_lru)
);

endmodule : icache

`default_nettype wire

// ==== icache_control.sv ====
`default_nettype none

module icache_control import rv32i_types::*; (
	input wire clk,
	input wire rst_n,
	input wire busy,
	input wire hit,
	input wire [num_ways-1:0] victim,
	input wire resp_ready,
	input wire pmem_resp,
	output logic accept,
	output logic resp_valid,
	output logic pmem_read,
	output logic [num_ways-1:0] load_line,
	output logic [num_ways-1:0] set_valid,
	output logic load_lru
);

enum logic [1:0] {
	idle,
	hit_detection,
	load,
	refill_done
} state, next_state;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= idle;
	end else begin
		state <= next_state;
	end
end

always_comb begin
	next_state = state;
	unique case (state)
		idle: next_state = hit_detection;
		hit_detection: begin
			if (busy && !hit) begin
				next_state = load;
			end
		end
		load: begin
			if (pmem_resp) begin
				next_state = refill_done;
			end
		end
		refill_done: next_state = hit_detection; // Look the address up again.
		default: next_state = idle;
	endcase
end

always_comb begin
	accept = 1'b0;
	resp_valid = 1'b0;
	pmem_read = 1'b0;
	load_line = '0;
	set_valid = '0;
	load_lru = 1'b0;
	unique case (state)
		idle: accept = 1'b1;
		hit_detection: begin
			if (!busy) begin
				accept = 1'b1; // Nothing in flight.
			end else if (hit) begin
				resp_valid = 1'b1;
				if (resp_ready) begin
					load_lru = 1'b1;
					accept = 1'b1; // Next fetch is captured as this one leaves.
				end
			end else begin
				pmem_read = 1'b1;
			end
		end
		load: begin
			pmem_read = 1'b1;
			if (pmem_resp) begin
				load_line = victim;
				set_valid = victim;
			end
		end
		refill_done: ;
		default: ;
	endcase
end

no_read_in_idle: assert property (
	@(posedge clk) disable iff (!rst_n)
	!(state == idle && pmem_read)
);

resp_needs_hit: assert property (
	@(posedge clk) disable iff (!rst_n)
	resp_valid |-> hit
);

// A pending response is held until the fetch side takes it.
resp_held: assert property (
	@(posedge clk) disable iff (!rst_n)
	resp_valid && !resp_ready |=> resp_valid
);

pmem_read_held: assert property (
	@(posedge clk) disable iff (!rst_n)
	pmem_read && !pmem_resp |=> pmem_read
);

endmodule : icache_control

`default_nettype wire

// ==== icache_request.sv ====
`default_nettype none

module icache_request import rv32i_types::*; (
	input wire clk,
	input wire rst_n,
	input wire req_valid,
	input wire [31:0] req_addr,
	input wire accept,
	output icache_addr_t addr,
	output logic busy
);

logic capture;

assign capture = accept && req_valid;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		busy <= 1'b0;
	end else if (accept) begin
		busy <= req_valid; // Empty accept cycle leaves nothing in flight.
	end
end

always_ff @(posedge clk) begin
	if (capture) begin
		addr.word <= req_addr;
	end
end

// The held address must stay put for the whole lookup, miss and refill.
held_addr_stable: assert property (
	@(posedge clk) disable iff (!rst_n)
	busy && !accept |=> $stable(addr.word)
);

endmodule : icache_request

`default_nettype wire

// ==== icache_way.sv ====
`default_nettype none

module icache_way import rv32i_types::*; (
	input wire clk,
	input wire rst_n,
	input wire icache_addr_t addr,
	input wire load_line,
	input wire set_valid,
	input wire icache_line_t fill_line,
	output logic hit,
	output icache_line_t line
);

logic [num_sets-1:0] valid;
logic [tag_bits-1:0] tags [num_sets];
icache_line_t lines [num_sets];

always_ff @(posedge clk) begin
	if (!rst_n) begin
		valid <= '0;
	end else if (set_valid) begin
		valid[addr.f.index] <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (load_line) begin
		tags[addr.f.index] <= addr.f.tag;
		lines[addr.f.index] <= fill_line;
	end
end

assign hit = valid[addr.f.index] && (tags[addr.f.index] == addr.f.tag);
assign line = lines[addr.f.index];

// Address is held through refill, so the new line hits on the next lookup.
fill_then_hit: assert property (
	@(posedge clk) disable iff (!rst_n)
	load_line && set_valid |=> hit
);

endmodule : icache_way

`default_nettype wire

// ==== icache_way_select.sv ====
`default_nettype none

module icache_way_select import rv32i_types::*; (
	input wire clk,
	input wire rst_n,
	input wire icache_addr_t addr,
	input wire [num_ways-1:0] way_hit,
	input wire icache_line_t way_line [num_ways],
	input wire load_lru,
	output logic hit,
	output logic [31:0] word,
	output logic [num_ways-1:0] victim
);

logic [num_sets-1:0] lru; // Names the next victim of each set.
logic [word_bits-1:0] word_sel;
logic lru_bit;

assign word_sel = addr.f.offset[offset_bits-1:byte_bits];
assign hit = |way_hit;

always_comb begin
	word = '0;
	for (int w = 0; w < num_ways; w++) begin
		if (way_hit[w]) begin
			word = word | way_line[w][word_sel];
		end
	end
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		lru <= '0;
	end else if (load_lru) begin
		lru[addr.f.index] <= way_hit[0]; // Way 0 used, so way 1 goes next.
	end
end

assign lru_bit = lru[addr.f.index];
assign victim = {lru_bit, ~lru_bit};

// Two ways holding the same tag in one set would corrupt the word mux.
one_way_hits: assert property (
	@(posedge clk) disable iff (!rst_n)
	$onehot0(way_hit)
);

endmodule : icache_way_select

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_icache -f src.f -o tb_icache \
	> sim.log 2>&1 \
	&& ./obj_dir/tb_icache >> sim.log 2>&1 \
	|| echo "ERRORS FOUND" >> sim.log
if grep -q "ERRORS FOUND" sim.log; then
	echo "FAIL"
	exit 1
fi
echo "PASS"

// ==== rv32i_types.sv ====
`default_nettype none

package rv32i_types;

localparam int num_ways = 2;
localparam int num_sets = 8;
localparam int line_words = 4;

localparam int offset_bits = 4; // Byte offset within a line.
localparam int index_bits = 3;
localparam int tag_bits = 25;

localparam int byte_bits = 2; // Byte within one word.
localparam int word_bits = offset_bits - byte_bits;

typedef struct packed {
	logic [tag_bits-1:0] tag;
	logic [index_bits-1:0] index;
	logic [offset_bits-1:0] offset;
} icache_fields_t;

// Fetch address, taken either whole or by field.
typedef union packed {
	logic [31:0] word;
	icache_fields_t f;
} icache_addr_t;

typedef logic [line_words-1:0][31:0] icache_line_t;

endpackage

`default_nettype wire

// ==== src.f ====
rv32i_types.sv
icache_request.sv
icache_way.sv
icache_way_select.sv
icache_control.sv
icache.sv
tb_pmem_model.sv
tb_icache.sv

// ==== tb_icache.sv ====
`default_nettype none

module tb_icache import rv32i_types::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int timeout_cycles = 200;
localparam int random_fetches = 200;
localparam logic [31:0] data_mask = 32'h5a5a0000;

logic clk;
logic rst_n;
logic req_valid;
logic req_ready;
logic [31:0] req_addr;
logic resp_valid;
logic resp_ready;
logic [31:0] resp_data;
logic pmem_read;
logic [31:0] pmem_addr;
logic pmem_resp;
icache_line_t pmem_rdata;

int miss_count;
int model_misses;
logic [31:0] last_pmem_addr;

logic [tag_bits-1:0] mru_tag [num_sets]; // Reference LRU, two tags per set.
logic [tag_bits-1:0] lru_tag [num_sets];
logic [num_sets-1:0] mru_valid;
logic [num_sets-1:0] lru_valid;

icache icache_i (
	.clk(clk),
	.rst_n(rst_n),
	.req_valid(req_valid),
	.req_ready(req_ready),
	.req_addr(req_addr),
	.resp_valid(resp_valid),
	.resp_ready(resp_ready),
	.resp_data(resp_data),
	.pmem_read(pmem_read),
	.pmem_addr(pmem_addr),
	.pmem_resp(pmem_resp),
	.pmem_rdata(pmem_rdata)
);

tb_pmem_model pmem_i (
	.clk(clk),
	.pmem_read(pmem_read),
	.pmem_addr(pmem_addr),
	.pmem_resp(pmem_resp),
	.pmem_rdata(pmem_rdata)
);

initial begin
	clk = 1'b0;
	forever begin
		#5 clk = ~clk;
	end
end

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		$display("ERRORS FOUND");
		$fatal(1, "Stopped at the first failing check.");
	end
endtask

task automatic abort_run(input string what);
	$display("%s at %0t ns", what, $time);
	$display("ERRORS FOUND");
	$fatal(1, "Stopped on a timeout.");
endtask

// Refill counter; the memory address must hold while a read is open.
initial begin
	logic read_q;
	read_q = 1'b0;
	miss_count = 0;
	last_pmem_addr = '0;
	forever begin
		@(posedge clk);
		#2;
		if (rst_n && pmem_read) begin
			if (!read_q) begin
				miss_count = miss_count + 1;
				last_pmem_addr = pmem_addr;
			end else begin
				check_value("pmem_addr", pmem_addr, last_pmem_addr);
			end
			check_value("pmem_addr offset", 32'(pmem_addr[offset_bits-1:0]), 32'd0);
		end
		read_q = pmem_read;
	end
end

function automatic logic [31:0] expected_word(input logic [31:0] addr);
	return {addr[31:2], 2'b00} ^ data_mask;
endfunction

// True LRU over two entries; returns 1 on a predicted miss.
function automatic logic model_access(input logic [31:0] addr);
	logic [index_bits-1:0] idx;
	logic [tag_bits-1:0] tag;
	logic miss;
	idx = addr[offset_bits +: index_bits];
	tag = addr[31 -: tag_bits];
	miss = 1'b0;
	if (mru_valid[idx] && mru_tag[idx] == tag) begin
		miss = 1'b0;
	end else if (lru_valid[idx] && lru_tag[idx] == tag) begin
		lru_tag[idx] = mru_tag[idx];
		mru_tag[idx] = tag;
	end else begin
		miss = 1'b1;
		lru_tag[idx] = mru_tag[idx];
		lru_valid[idx] = mru_valid[idx];
		mru_tag[idx] = tag;
		mru_valid[idx] = 1'b1;
	end
	return miss;
endfunction

// Starts and ends 1 ns after a rising edge. Samples 2 ns after the edge.
task automatic fetch_word(input logic [31:0] addr, input int hold,
		output logic [31:0] data, output int latency);
	int cycles;
	logic [31:0] held_data;
	req_addr = addr;
	req_valid = 1'b1;
	resp_ready = (hold == 0);
	#1;
	cycles = 0;
	while (!req_ready) begin
		if (cycles == timeout_cycles) begin
			abort_run("Request was never accepted");
		end
		cycles++;
		@(posedge clk);
		#2;
	end
	@(posedge clk);
	#1;
	req_valid = 1'b0;
	#1;
	cycles = 0;
	while (!resp_valid) begin
		if (cycles == timeout_cycles) begin
			abort_run("No response arrived");
		end
		cycles++;
		@(posedge clk);
		#2;
	end
	latency = cycles;
	if (hold > 0) begin
		held_data = resp_data;
		check_value("req_ready while stalled", 32'(req_ready), 32'd0);
		for (int i = 0; i < hold; i++) begin
			@(posedge clk);
			#1;
			req_valid = (i < hold - 1); // A competing fetch that must wait.
			req_addr = addr ^ 32'h0000_0100;
			resp_ready = (i == hold - 1);
			#1;
			check_value("resp_valid while stalled", 32'(resp_valid), 32'd1);
			check_value("resp_data while stalled", resp_data, held_data);
			if (i < hold - 1) begin
				check_value("req_ready while stalled", 32'(req_ready), 32'd0);
			end
		end
	end
	data = resp_data;
	check_value("req_ready as response completes", 32'(req_ready), 32'd1);
	@(posedge clk);
	#1;
	resp_ready = 1'b1;
endtask

task automatic access_word(input logic [31:0] addr, input int hold,
		output logic missed, output int latency);
	int misses_before;
	logic [31:0] data;
	missed = model_access(addr);
	misses_before = miss_count;
	fetch_word(addr, hold, data, latency);
	check_value("resp_data", data, expected_word(addr));
	check_value("pmem_read count", 32'(miss_count - misses_before), 32'(missed));
	model_misses = model_misses + 32'(missed);
endtask

task automatic reset_state();
	#1;
	check_value("req_ready after reset", 32'(req_ready), 32'd1);
	check_value("resp_valid after reset", 32'(resp_valid), 32'd0);
	check_value("pmem_read after reset", 32'(pmem_read), 32'd0);
	@(posedge clk);
	#1;
endtask

task automatic cold_miss();
	logic missed;
	int latency;
	access_word(32'h0000_1004, 0, missed, latency);
	check_value("cold miss predicted", 32'(missed), 32'd1);
	check_value("refill address", last_pmem_addr, 32'h0000_1000);
endtask

task automatic hits_after_fill();
	logic [31:0] addr;
	logic missed;
	int latency;
	for (int i = 0; i < line_words; i++) begin
		addr = 32'h0000_1000 + 32'(i * 4);
		if (addr != 32'h0000_1004) begin
			access_word(addr, 0, missed, latency);
			check_value("hit predicted", 32'(missed), 32'd0);
			check_value("hit latency", 32'(latency), 32'd0);
		end
	end
endtask

task automatic lru_replacement();
	logic [31:0] order_addr [6];
	logic order_miss [6];
	logic missed;
	int latency;
	// Set 1 sees A, B, A, C, then A and B once more.
	order_addr = '{32'h0000_2010, 32'h0000_3010, 32'h0000_2010,
		32'h0000_4010, 32'h0000_2014, 32'h0000_3018};
	order_miss = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
	for (int i = 0; i < 6; i++) begin
		access_word(order_addr[i], 0, missed, latency);
		check_value("LRU miss prediction", 32'(missed), 32'(order_miss[i]));
	end
endtask

task automatic back_pressure();
	logic missed;
	int latency;
	int hold;
	hold = $urandom_range(2, 8);
	access_word(32'h0000_2018, hold, missed, latency);
	hold = $urandom_range(2, 8);
	access_word(32'h0000_5020, hold, missed, latency); // Cold set, so a refill.
endtask

task automatic random_run();
	logic [31:0] addr;
	logic missed;
	int latency;
	int hold;
	int misses_before;
	int model_before;
	misses_before = miss_count;
	model_before = model_misses;
	for (int n = 0; n < random_fetches; n++) begin
		addr = 32'h0001_0000 + ($urandom_range(0, 255) << 2); // 1 KB, eight tags a set.
		hold = 0;
		if ($urandom_range(0, 3) == 0) begin
			hold = $urandom_range(1, 4);
		end
		access_word(addr, hold, missed, latency);
	end
	check_value("random run pmem_read count", 32'(miss_count - misses_before),
		32'(model_misses - model_before));
endtask

initial begin
	void'($urandom(32'h1ecac09f));
	model_misses = 0;
	mru_valid = '0;
	lru_valid = '0;
	rst_n = 1'b0;
	req_valid = 1'b0;
	req_addr = '0;
	resp_ready = 1'b1;
	repeat (4) @(posedge clk);
	#1;
	rst_n = 1'b1;
	reset_state();
	cold_miss();
	hits_after_fill();
	lru_replacement();
	back_pressure();
	random_run();
	$display("NO ERRORS");
	$finish;
end

endmodule : tb_icache

`default_nettype wire

// ==== tb_pmem_model.sv ====
`default_nettype none

module tb_pmem_model import rv32i_types::*; (
	input wire clk,
	input wire pmem_read,
	input wire [31:0] pmem_addr,
	output logic pmem_resp,
	output icache_line_t pmem_rdata
);

timeunit 1ns;
timeprecision 100ps;

localparam int latency = 4; // Cycles of pmem_read before the response pulse.
localparam logic [31:0] data_mask = 32'h5a5a0000;

int wait_count;

// Outputs change 1 ns after the rising edge.
initial begin
	pmem_resp = 1'b0;
	pmem_rdata = '0;
	wait_count = 0;
	forever begin
		@(posedge clk);
		#1;
		if (pmem_resp) begin
			pmem_resp = 1'b0; // One-cycle pulse.
			pmem_rdata = '0;
			wait_count = 0;
		end else if (pmem_read) begin
			wait_count = wait_count + 1;
			if (wait_count >= latency) begin
				pmem_resp = 1'b1;
				for (int i = 0; i < line_words; i++) begin
					pmem_rdata[i] = (pmem_addr + 32'(i * 4)) ^ data_mask;
				end
			end
		end else begin
			wait_count = 0;
		end
	end
end

endmodule : tb_pmem_model

`default_nettype wire
